//--- hw/gpio_bus_pkg.sv
// Peripheral bus package: request struct, data widths and GPIO block address decode

package gpio_bus_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------
  localparam int ADDR_W = 14;                // Word address
  localparam int DATA_W = 16;                // Two byte lanes

  typedef logic [ADDR_W-1:0] gpio_addr_t;
  typedef logic [DATA_W-1:0] gpio_data_t;

  // ------------------------------------------------------------------------
  // Block decode
  // ------------------------------------------------------------------------

  // Low address bits seen inside the block, the rest must match the base
  localparam int DEC_W = 5;

  // Picks port 2 over port 1 within the register window
  localparam int PORT_SEL_BIT = 2;

  // First register word, base address fixed at zero
  localparam gpio_addr_t REG_BASE_WORD = 14'h0010;

  // ------------------------------------------------------------------------
  // Request from the bus master
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic       en;      // Access strobe
    logic [1:0] we;      // Bit 1 high lane, bit 0 low lane
    gpio_addr_t addr;
    gpio_data_t din;
  } gpio_bus_req_t;

endpackage

//--- hw/gpio_port_pkg.sv
// Port package: register word map, pad output bundle and per-port register access

package gpio_port_pkg;

  import gpio_bus_pkg::gpio_data_t;

  localparam int PIN_W = 8;                  // Pins per port

  typedef logic [PIN_W-1:0] gpio_pins_t;

  // ------------------------------------------------------------------------
  // Register words inside one port, low byte / high byte
  // ------------------------------------------------------------------------
  typedef logic [1:0] gpio_word_idx_t;

  localparam gpio_word_idx_t WORD_IN_OUT  = 2'd0;  // IN  / OUT
  localparam gpio_word_idx_t WORD_DIR_IFG = 2'd1;  // DIR / IFG
  localparam gpio_word_idx_t WORD_IES_IE  = 2'd2;  // IES / IE
  localparam gpio_word_idx_t WORD_SEL     = 2'd3;  // SEL / reads zero

  // Input synchronizer depth
  localparam int SYNC_STAGES = 2;

  // ------------------------------------------------------------------------
  // Pad side of a port
  // ------------------------------------------------------------------------
  typedef struct packed {
    gpio_pins_t dout;     // Output data
    gpio_pins_t dout_en;  // Output enable
    gpio_pins_t sel;      // Function select
  } gpio_pad_out_t;

  // Register access routed from the bus slave to one port
  typedef struct packed {
    gpio_word_idx_t word;
    logic [1:0]     we;     // Zero when the other port is addressed
    gpio_data_t     wdata;
  } gpio_reg_acc_t;

endpackage

//--- hw/gpio_irq_unit.sv
// GPIO interrupt unit: pin edge detection, flag register and port interrupt line
`timescale 1ns/1ps

module gpio_irq_unit (
  input  logic                      mclk,
  input  logic                      puc_rst,
  input  gpio_port_pkg::gpio_pins_t pins,
  input  gpio_port_pkg::gpio_pins_t ies,
  input  gpio_port_pkg::gpio_pins_t ie,
  input  logic                      ifg_we,
  input  gpio_port_pkg::gpio_pins_t ifg_wdata,
  output gpio_port_pkg::gpio_pins_t ifg,
  output logic                      irq
);

  import gpio_port_pkg::*;

  gpio_pins_t pins_dly;   // Pins one cycle back
  gpio_pins_t rise;
  gpio_pins_t fall;
  gpio_pins_t set_vec;
  gpio_pins_t ifg_q;

  // ------------------------------------------------------------------------
  // Edge detection
  // ------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      pins_dly <= '0;
    end else begin
      pins_dly <= pins;
    end
  end

  assign rise = pins & ~pins_dly;
  assign fall = ~pins & pins_dly;

  // IES high selects the falling edge
  assign set_vec = (ies & fall) | (~ies & rise);

  // ------------------------------------------------------------------------
  // Flag register
  // ------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ifg_q <= '0;
    end else if (ifg_we) begin
      ifg_q <= ifg_wdata | set_vec;   // A new edge beats a clearing write
    end else begin
      ifg_q <= ifg_q | set_vec;
    end
  end

  assign ifg = ifg_q;
  assign irq = |(ie & ifg_q);

endmodule

//--- hw/gpio_port.sv
// GPIO port: input synchronizer, configuration registers and register read mux
`timescale 1ns/1ps

module gpio_port (
  input  logic                         mclk,
  input  logic                         puc_rst,
  input  gpio_port_pkg::gpio_reg_acc_t acc,
  input  gpio_port_pkg::gpio_pins_t    din,
  output gpio_port_pkg::gpio_pad_out_t pad,
  output gpio_bus_pkg::gpio_data_t     rd_word,
  output logic                         irq
);

  import gpio_port_pkg::*;

  logic [SYNC_STAGES-1:0][PIN_W-1:0] sync_q;
  gpio_pins_t    pins_in;    // Synchronized pins, the IN register
  gpio_pins_t    lo_byte;
  gpio_pins_t    hi_byte;
  gpio_pad_out_t pad_q;      // OUT, DIR and SEL
  gpio_pins_t    ies_q;
  gpio_pins_t    ie_q;
  gpio_pins_t    ifg;
  logic          out_wr;
  logic          dir_wr;
  logic          ifg_we;
  logic          ies_wr;
  logic          ie_wr;
  logic          sel_wr;

  // ------------------------------------------------------------------------
  // Input synchronizer
  // ------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], din};
    end
  end

  assign pins_in = sync_q[SYNC_STAGES-1];

  // ------------------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------------------
  assign lo_byte = acc.wdata[PIN_W-1:0];
  assign hi_byte = acc.wdata[2*PIN_W-1:PIN_W];

  // IN sits in the low lane of word 0 and has no write path
  assign out_wr = acc.we[1] & (acc.word == WORD_IN_OUT);
  assign dir_wr = acc.we[0] & (acc.word == WORD_DIR_IFG);
  assign ifg_we = acc.we[1] & (acc.word == WORD_DIR_IFG);
  assign ies_wr = acc.we[0] & (acc.word == WORD_IES_IE);
  assign ie_wr  = acc.we[1] & (acc.word == WORD_IES_IE);
  assign sel_wr = acc.we[0] & (acc.word == WORD_SEL);

  // Configuration registers
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      pad_q <= '0;
      ies_q <= '0;
      ie_q  <= '0;
    end else begin
      if (out_wr) pad_q.dout    <= hi_byte;
      if (dir_wr) pad_q.dout_en <= lo_byte;
      if (sel_wr) pad_q.sel     <= lo_byte;
      if (ies_wr) ies_q         <= lo_byte;
      if (ie_wr)  ie_q          <= hi_byte;
    end
  end

  assign pad = pad_q;

  // Edge flags and interrupt line
  gpio_irq_unit u_irq (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .pins      (pins_in),
    .ies       (ies_q),
    .ie        (ie_q),
    .ifg_we    (ifg_we),
    .ifg_wdata (hi_byte),
    .ifg       (ifg),
    .irq       (irq)
  );

  // ------------------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------------------
  always_comb begin
    case (acc.word)
      WORD_IN_OUT:  rd_word = {pad_q.dout, pins_in};
      WORD_DIR_IFG: rd_word = {ifg, pad_q.dout_en};
      WORD_IES_IE:  rd_word = {ie_q, ies_q};
      default:      rd_word = {{PIN_W{1'b0}}, pad_q.sel};  // Upper byte unused
    endcase
  end

endmodule

//--- hw/gpio_bus_slave.sv
// GPIO bus slave: decodes the register window and routes accesses to the two ports
`timescale 1ns/1ps

module gpio_bus_slave (
  input  gpio_bus_pkg::gpio_bus_req_t  bus_req,
  output gpio_port_pkg::gpio_reg_acc_t p1_acc,
  output gpio_port_pkg::gpio_reg_acc_t p2_acc,
  input  gpio_bus_pkg::gpio_data_t     p1_rd_word,
  input  gpio_bus_pkg::gpio_data_t     p2_rd_word,
  output gpio_bus_pkg::gpio_data_t     per_dout
);

  import gpio_bus_pkg::*;
  import gpio_port_pkg::*;

  logic           base_hit;   // Upper bits match the block base
  logic           win_hit;    // Inside words 0x10 to 0x17
  logic           reg_sel;
  logic           port2;
  logic           reg_rd;
  gpio_word_idx_t word_idx;
  gpio_reg_acc_t  acc_base;

  // ------------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------------
  assign base_hit = bus_req.addr[ADDR_W-1:DEC_W] == REG_BASE_WORD[ADDR_W-1:DEC_W];

  // Bits between the port select and the decode width pick the window
  assign win_hit = bus_req.addr[DEC_W-1:PORT_SEL_BIT+1] ==
                   REG_BASE_WORD[DEC_W-1:PORT_SEL_BIT+1];

  assign reg_sel  = bus_req.en & base_hit & win_hit;
  assign port2    = bus_req.addr[PORT_SEL_BIT];
  assign word_idx = bus_req.addr[$bits(gpio_word_idx_t)-1:0];

  // No lane enabled means read
  assign reg_rd = reg_sel & ~|bus_req.we;

  // ------------------------------------------------------------------------
  // Access routing
  // ------------------------------------------------------------------------
  always_comb begin
    acc_base.word  = word_idx;   // Both ports see the word index
    acc_base.we    = 2'b00;
    acc_base.wdata = bus_req.din;

    p1_acc = acc_base;
    p2_acc = acc_base;

    // Lane enables reach only the addressed port
    if (reg_sel) begin
      if (port2) begin
        p2_acc.we = bus_req.we;
      end else begin
        p1_acc.we = bus_req.we;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Read data
  // ------------------------------------------------------------------------
  always_comb begin
    per_dout = '0;                       // Idle, writes and misses read zero
    if (reg_rd) begin
      per_dout = port2 ? p2_rd_word : p1_rd_word;
    end
  end

endmodule

//--- hw/gpio_top.sv
// GPIO peripheral top: bus slave feeding two identical ports
`timescale 1ns/1ps

module gpio_top (
  input  logic                         mclk,
  input  logic                         puc_rst,
  input  gpio_bus_pkg::gpio_bus_req_t  bus_req,
  input  gpio_port_pkg::gpio_pins_t    p1_din,
  input  gpio_port_pkg::gpio_pins_t    p2_din,
  output gpio_bus_pkg::gpio_data_t     per_dout,
  output gpio_port_pkg::gpio_pad_out_t p1_pad,
  output gpio_port_pkg::gpio_pad_out_t p2_pad,
  output logic                         irq_port1,
  output logic                         irq_port2
);

  import gpio_bus_pkg::*;
  import gpio_port_pkg::*;

  gpio_reg_acc_t p1_acc;
  gpio_reg_acc_t p2_acc;
  gpio_data_t    p1_rd_word;
  gpio_data_t    p2_rd_word;

  // Register window decode
  gpio_bus_slave u_slave (
    .bus_req    (bus_req),
    .p1_acc     (p1_acc),
    .p2_acc     (p2_acc),
    .p1_rd_word (p1_rd_word),
    .p2_rd_word (p2_rd_word),
    .per_dout   (per_dout)
  );

  gpio_port u_port1 (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .acc     (p1_acc),
    .din     (p1_din),
    .pad     (p1_pad),
    .rd_word (p1_rd_word),
    .irq     (irq_port1)
  );

  gpio_port u_port2 (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .acc     (p2_acc),
    .din     (p2_din),
    .pad     (p2_pad),
    .rd_word (p2_rd_word),
    .irq     (irq_port2)
  );

endmodule

//--- bench/gpio_tb.sv
// GPIO testbench with random register traffic and pin activity checked against a register model
`timescale 1ns/1ps

module gpio_tb;

  import gpio_bus_pkg::*;
  import gpio_port_pkg::*;

  // Cycle budget of each test
  localparam int RST_CYC = 10;
  localparam int T1_CYC  = 8;
  localparam int T2_CYC  = 200 * 3;
  localparam int T3_CYC  = 40 * 6 + 8;
  localparam int T4_CYC  = 10 * 8;
  localparam int T5_CYC  = 20 * 8 + 5 * 8;
  localparam int T6_CYC  = 20 * 3;
  localparam int LIMIT   = 2 * (RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC);

  logic          mclk;
  logic          puc_rst;
  gpio_bus_req_t bus_req;
  gpio_pins_t    p1_din;
  gpio_pins_t    p2_din;
  gpio_data_t    per_dout;
  gpio_pad_out_t p1_pad;
  gpio_pad_out_t p2_pad;
  logic          irq_port1;
  logic          irq_port2;

  integer seed   = 55;
  int     cycles = 0;

  // Register model with index 0 for port 1
  gpio_pins_t m_out  [2] = '{default: '0};
  gpio_pins_t m_dir  [2] = '{default: '0};
  gpio_pins_t m_sel  [2] = '{default: '0};
  gpio_pins_t m_ies  [2] = '{default: '0};
  gpio_pins_t m_ie   [2] = '{default: '0};
  gpio_pins_t m_ifg  [2] = '{default: '0};
  gpio_pins_t m_pins [2] = '{default: '0};  // Levels held at the pins

  gpio_top DUT (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .bus_req   (bus_req),
    .p1_din    (p1_din),
    .p2_din    (p2_din),
    .per_dout  (per_dout),
    .p1_pad    (p1_pad),
    .p2_pad    (p2_pad),
    .irq_port1 (irq_port1),
    .irq_port2 (irq_port2)
  );

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;
  end

  always @(posedge mclk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      fail_run($sformatf("Timeout, the run did not finish within %0d cycles", LIMIT));
    end
  end

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Simulation stopped at cycle %0d", cycles);
  endtask

  task automatic check_word(string name, gpio_data_t got, gpio_data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pad(string name, gpio_pad_out_t got, gpio_pad_out_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_irq(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // Model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic in_window(gpio_addr_t addr);
    return (addr >= 14'h10) && (addr <= 14'h17);
  endfunction

  function automatic gpio_data_t expected_word(gpio_addr_t addr);
    logic       pi;
    gpio_data_t w;
    pi = addr[2];   // Port 2 at 0x14 to 0x17
    w  = '0;
    if (in_window(addr)) begin
      case (addr[1:0])
        2'd0:    w = {m_out[pi], m_pins[pi]};
        2'd1:    w = {m_ifg[pi], m_dir[pi]};
        2'd2:    w = {m_ie[pi], m_ies[pi]};
        default: w = {8'h00, m_sel[pi]};
      endcase
    end
    return w;
  endfunction

  task automatic model_write(gpio_bus_req_t req);
    logic       pi;
    gpio_pins_t lo;
    gpio_pins_t hi;
    pi = req.addr[2];
    lo = req.din[7:0];
    hi = req.din[15:8];
    if (req.en && in_window(req.addr) && req.we != 2'b00) begin
      case (req.addr[1:0])
        2'd0: if (req.we[1]) m_out[pi] = hi;   // Low lane is IN
        2'd1: begin
          if (req.we[0]) m_dir[pi] = lo;
          if (req.we[1]) m_ifg[pi] = hi;
        end
        2'd2: begin
          if (req.we[0]) m_ies[pi] = lo;
          if (req.we[1]) m_ie[pi] = hi;
        end
        default: if (req.we[0]) m_sel[pi] = lo;
      endcase
    end
  endtask

  // Rising edge flags where IES is 0 and falling where it is 1
  task automatic update_flags(logic pi, gpio_pins_t nv);
    m_ifg[pi]  = m_ifg[pi] | (m_ies[pi] & ~nv & m_pins[pi]) | (~m_ies[pi] & nv & ~m_pins[pi]);
    m_pins[pi] = nv;
  endtask

  // --------------------------------------------------------------------------
  // Bus and pin drivers
  // --------------------------------------------------------------------------
  function automatic gpio_bus_req_t make_req(logic en, logic [1:0] we, gpio_addr_t addr,
                                             gpio_data_t din);
    gpio_bus_req_t r;
    r.en   = en;
    r.we   = we;
    r.addr = addr;
    r.din  = din;
    return r;
  endfunction

  task automatic drive_cycle(gpio_bus_req_t req);
    @(negedge mclk);
    bus_req = req;
    #1 check_word("per_dout", per_dout, 16'h0000);   // Writes read zero
    @(negedge mclk);
    bus_req = '0;
    model_write(req);
  endtask

  task automatic read_bus(gpio_bus_req_t req, output gpio_data_t data);
    @(negedge mclk);
    bus_req = req;
    #1 data = per_dout;   // Combinational read data
  endtask

  task automatic read_check(gpio_addr_t addr);
    gpio_data_t data;
    read_bus(make_req(1'b1, 2'b00, addr, '0), data);
    check_word("per_dout", data, expected_word(addr));
  endtask

  task automatic verify_all_words();
    gpio_addr_t a;
    a = 14'h10;
    repeat (8) begin
      read_check(a);
      a = a + 14'd1;
    end
  endtask

  task automatic check_outputs();
    check_pad("p1_pad", p1_pad, {m_out[0], m_dir[0], m_sel[0]});
    check_pad("p2_pad", p2_pad, {m_out[1], m_dir[1], m_sel[1]});
    check_irq("irq_port1", irq_port1, |(m_ie[0] & m_ifg[0]));
    check_irq("irq_port2", irq_port2, |(m_ie[1] & m_ifg[1]));
  endtask

  // Pins held 4 cycles so IN and the edge flags settle
  task automatic apply_pins(gpio_pins_t v1, gpio_pins_t v2);
    @(negedge mclk);
    p1_din = v1;
    p2_din = v2;
    update_flags(1'b0, v1);
    update_flags(1'b1, v2);
    repeat (4) @(negedge mclk);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [1:0]  we;
    gpio_addr_t  a;
    gpio_data_t  d;
    puc_rst = 1'b1;
    bus_req = '0;
    p1_din  = '0;
    p2_din  = '0;
    repeat (RST_CYC) @(posedge mclk);
    @(negedge mclk);
    puc_rst = 1'b0;

    check_outputs();   // Reset values
    verify_all_words();

    repeat (200) begin
      r  = rnd();
      a  = 14'h10 | {11'd0, r[2:0]};
      we = r[4:3];
      if (we == 2'b00) we = 2'b11;
      drive_cycle(make_req(1'b1, we, a, r[31:16]));
      read_check(a);
      check_outputs();
    end

    // Misses and idle cycles
    repeat (40) begin
      r = rnd();
      a = r[13:0];
      if (r[14]) a = {9'd0, r[4:0]};   // Half the misses land next to the window
      if (in_window(a)) a = a ^ (r[15] ? 14'h0100 : 14'h0008);
      read_check(a);
      r = rnd();
      drive_cycle(make_req(1'b1, r[1:0] | 2'b01, a, r[31:16]));
      a = 14'h10 | {11'd0, r[4:2]};
      read_bus(make_req(1'b0, 2'b00, a, '0), d);
      check_word("per_dout", d, 16'h0000);
      drive_cycle(make_req(1'b0, r[6:5] | 2'b10, a, r[31:16]));
      check_outputs();
    end
    verify_all_words();

    repeat (10) begin
      r = rnd();
      apply_pins(r[7:0], r[15:8]);
      read_check(14'h10);
      read_check(14'h14);
    end

    // Edge flags from a clean start
    drive_cycle(make_req(1'b1, 2'b10, 14'h11, 16'h0000));
    drive_cycle(make_req(1'b1, 2'b10, 14'h15, 16'h0000));
    for (int i = 0; i < 20; i++) begin
      if (i % 5 == 0) begin
        r = rnd();
        drive_cycle(make_req(1'b1, 2'b11, 14'h12, r[15:0]));
        drive_cycle(make_req(1'b1, 2'b11, 14'h16, r[31:16]));
      end
      r = rnd();
      apply_pins(r[7:0], r[15:8]);
      read_check(14'h11);
      read_check(14'h15);
      check_outputs();
    end

    // Software IFG writes with the pins steady
    repeat (20) begin
      r = rnd();
      a = r[16] ? 14'h15 : 14'h11;
      drive_cycle(make_req(1'b1, 2'b10, a, r[15:0]));
      read_check(a);
      check_outputs();
    end

    $display("No errors");
    $finish;
  end

endmodule

//--- compile.f
hw/gpio_bus_pkg.sv
hw/gpio_port_pkg.sv
hw/gpio_irq_unit.sv
hw/gpio_port.sv
hw/gpio_bus_slave.sv
hw/gpio_top.sv
bench/gpio_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := gpio_tb
FILELIST  := compile.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --top-module $(TOP) --Mdir $(OBJDIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
